//--- common/streamer_pkg.sv
// Streamer shared definitions
// Widths, channel indices, register map and channel state encoding
package streamer_pkg;

  // Default word and address widths, overridden from the top level
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 16;

  // Width of length fields and word counters
  localparam int unsigned LEN_W = 12;

  // Load channels X, W and Y
  localparam int unsigned NUM_SOURCES = 3;
  localparam int unsigned X_ID = 0;
  localparam int unsigned W_ID = 1;
  localparam int unsigned Y_ID = 2;

  // Arbiter inputs, the store channel sits after the loads
  localparam int unsigned NUM_PORTS = 4;

  // Response FIFO depth of one load channel
  localparam int unsigned FIFO_DEPTH = 4;

  typedef logic [1:0] chan_id_t;

  // Field order per channel is base, stride, length
  typedef enum logic [3:0] {
    REG_CTRL,
    REG_STATUS,
    REG_X_BASE,
    REG_X_STRIDE,
    REG_X_LEN,
    REG_W_BASE,
    REG_W_STRIDE,
    REG_W_LEN,
    REG_Y_BASE,
    REG_Y_STRIDE,
    REG_Y_LEN,
    REG_Z_BASE,
    REG_Z_STRIDE,
    REG_Z_LEN
  } reg_addr_e;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } chan_state_e;

endpackage

//--- common/mem_port_if.sv
// Memory port between channels, arbiter and the top level
// Request strobes with a one-cycle read response
`timescale 1ns/1ps

interface mem_port_if #(
  parameter int unsigned DATA_W = 32,
  parameter int unsigned ADDR_W = 16
);

  // Request side, held until req and gnt meet
  logic              req;
  logic              gnt;
  logic [ADDR_W-1:0] addr;
  // High for a read
  logic              wen;
  logic [DATA_W-1:0] wdata;

  // One response per accepted read, one cycle later
  logic              r_valid;
  logic [DATA_W-1:0] r_data;

  modport initiator (
    output req, addr, wen, wdata,
    input  gnt, r_valid, r_data
  );

  modport target (
    input  req, addr, wen, wdata,
    output gnt, r_valid, r_data
  );

endinterface

//--- common/word_stream_if.sv
// Word stream with valid/ready handshake
`timescale 1ns/1ps

interface word_stream_if #(
  parameter int unsigned DATA_W = 32
);

  // Word moves when valid and ready are both high
  logic              valid;
  logic              ready;
  logic [DATA_W-1:0] data;

  modport source (
    output valid, data,
    input  ready
  );

  modport sink (
    input  valid, data,
    output ready
  );

endinterface

//--- streamer/stream_source.sv
// Load channel of the streamer
// Issues strided reads and buffers responses into an outgoing word stream
`timescale 1ns/1ps

module stream_source #(
  parameter int unsigned DATA_W     = streamer_pkg::DATA_W,
  parameter int unsigned ADDR_W     = streamer_pkg::ADDR_W,
  parameter int unsigned FIFO_DEPTH = streamer_pkg::FIFO_DEPTH
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           start_i,
  input  logic [ADDR_W-1:0]              base_i,
  input  logic [ADDR_W-1:0]              stride_i,
  input  logic [streamer_pkg::LEN_W-1:0] len_i,
  output logic                           finished_o,
  mem_port_if.initiator                  mem,
  word_stream_if.source                  stream_o
);
  import streamer_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  chan_state_e       state_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  issue_left_q;
  logic [LEN_W-1:0]  out_left_q;
  logic [CNT_W-1:0]  inflight_q;
  logic [CNT_W-1:0]  count_q;
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [DATA_W-1:0] fifo_q [FIFO_DEPTH];
  logic [CNT_W:0]    credit_used;
  logic              accept;
  logic              push;
  logic              pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Reads in flight plus words held, a slot is reserved per request
  assign credit_used = inflight_q + count_q;

  // RUN always has at least one read left to issue
  assign mem.req   = (state_q == RUN) && (credit_used < FIFO_DEPTH);
  assign mem.addr  = addr_q;
  assign mem.wen   = 1'b1;
  assign mem.wdata = '0;

  assign accept = mem.req && mem.gnt;
  assign push   = mem.r_valid;
  assign pop    = stream_o.valid && stream_o.ready;

  // Stream shows the FIFO head
  assign stream_o.valid = (count_q != '0);
  assign stream_o.data  = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= mem.r_data;
    end
  end

  // Address walks by stride once per accepted read
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= base_i;
    end else if (accept) begin
      addr_q <= addr_q + stride_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= IDLE;
      issue_left_q <= '0;
      out_left_q   <= '0;
      inflight_q   <= '0;
      count_q      <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      finished_o   <= 1'b0;
    end else begin
      // A response moves one credit from in flight to the FIFO
      inflight_q <= inflight_q + CNT_W'(accept) - CNT_W'(push);
      count_q    <= count_q + CNT_W'(push) - CNT_W'(pop);
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q   <= next_ptr(rd_ptr_q);
        out_left_q <= out_left_q - 1'b1;
      end
      if (accept) begin
        issue_left_q <= issue_left_q - 1'b1;
      end
      if (start_i) begin
        issue_left_q <= len_i;
        out_left_q   <= len_i;
        // Zero length is done right away
        finished_o   <= (len_i == '0);
        state_q      <= (len_i == '0) ? IDLE : RUN;
      end else begin
        case (state_q)
          // Last read accepted, wait for the FIFO to empty
          RUN: begin
            if (accept && issue_left_q == LEN_W'(1)) begin
              state_q <= DRAIN;
            end
          end
          DRAIN: begin
            if (pop && out_left_q == LEN_W'(1)) begin
              state_q    <= IDLE;
              finished_o <= 1'b1;
            end
          end
          default: state_q <= state_q;
        endcase
      end
    end
  end

endmodule

//--- streamer/stream_sink.sv
// Store channel of the streamer
// Turns each incoming Z word into one strided write request
`timescale 1ns/1ps

module stream_sink #(
  parameter int unsigned DATA_W = streamer_pkg::DATA_W,
  parameter int unsigned ADDR_W = streamer_pkg::ADDR_W
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           start_i,
  input  logic [ADDR_W-1:0]              base_i,
  input  logic [ADDR_W-1:0]              stride_i,
  input  logic [streamer_pkg::LEN_W-1:0] len_i,
  output logic                           finished_o,
  mem_port_if.initiator                  mem,
  word_stream_if.sink                    stream_i
);
  import streamer_pkg::*;

  chan_state_e       state_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  left_q;
  logic              accept;

  // Write request only while a Z word waits
  assign mem.req   = (state_q == RUN) && stream_i.valid;
  assign mem.addr  = addr_q;
  assign mem.wen   = 1'b0;
  assign mem.wdata = stream_i.data;

  // Word is consumed in the grant cycle
  assign accept         = mem.req && mem.gnt;
  assign stream_i.ready = accept;

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= base_i;
    end else if (accept) begin
      addr_q <= addr_q + stride_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= IDLE;
      left_q     <= '0;
      finished_o <= 1'b0;
    end else if (start_i) begin
      left_q     <= len_i;
      finished_o <= (len_i == '0);
      state_q    <= (len_i == '0) ? IDLE : RUN;
    end else if (accept) begin
      left_q <= left_q - 1'b1;
      // Last write granted
      if (left_q == LEN_W'(1)) begin
        state_q    <= IDLE;
        finished_o <= 1'b1;
      end
    end
  end

endmodule

//--- streamer/ldst_arbiter.sv
// Load/store arbiter of the streamer
// Round-robin over four channels onto one memory port, read responses routed back
`timescale 1ns/1ps

module ldst_arbiter #(
  parameter int unsigned DATA_W = streamer_pkg::DATA_W,
  parameter int unsigned ADDR_W = streamer_pkg::ADDR_W
) (
  input  logic          clk_i,
  input  logic          reset_i,
  mem_port_if.target    chan [streamer_pkg::NUM_PORTS],
  mem_port_if.initiator mem
);
  import streamer_pkg::*;

  logic [NUM_PORTS-1:0] req_vec;
  logic [NUM_PORTS-1:0] wen_vec;
  logic [ADDR_W-1:0]    addr_arr [NUM_PORTS];
  logic [DATA_W-1:0]    wdata_arr [NUM_PORTS];
  chan_id_t             rr_q;
  chan_id_t             sel;
  chan_id_t             pend_id_q;
  logic                 found;
  logic                 accept;
  logic                 pend_q;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
    assign req_vec[i]   = chan[i].req;
    assign wen_vec[i]   = chan[i].wen;
    assign addr_arr[i]  = chan[i].addr;
    assign wdata_arr[i] = chan[i].wdata;
    // Grant only reaches the selected channel
    assign chan[i].gnt    = mem.gnt && found && (sel == chan_id_t'(i));
    assign chan[i].r_data = mem.r_data;
    if (i < NUM_SOURCES) begin : g_load
      assign chan[i].r_valid = mem.r_valid && pend_q && (pend_id_q == chan_id_t'(i));
    end else begin : g_store
      // Writes have no response
      assign chan[i].r_valid = 1'b0;
    end
  end

  // First requester at or after the pointer
  always_comb begin
    chan_id_t idx;
    sel   = rr_q;
    found = 1'b0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      idx = chan_id_t'(rr_q + k);
      if (!found && req_vec[idx]) begin
        sel   = idx;
        found = 1'b1;
      end
    end
  end

  assign mem.req   = found;
  assign mem.addr  = addr_arr[sel];
  assign mem.wen   = wen_vec[sel];
  assign mem.wdata = wdata_arr[sel];
  assign accept    = found && mem.gnt;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q      <= '0;
      pend_q    <= 1'b0;
      pend_id_q <= '0;
    end else begin
      // Response arrives the cycle after a read is accepted
      pend_q <= accept && mem.wen;
      if (accept) begin
        pend_id_q <= sel;
        rr_q      <= sel + 1'b1;
      end else if (found) begin
        // Pointer parks on a waiting request so the port stays stable
        rr_q <= sel;
      end
    end
  end

endmodule

//--- hw/streamer_regs.sv
// Streamer configuration and status registers
// Per-channel base, stride and length, start pulse and busy/done tracking
`timescale 1ns/1ps

module streamer_regs #(
  parameter int unsigned DATA_W = streamer_pkg::DATA_W,
  parameter int unsigned ADDR_W = streamer_pkg::ADDR_W
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               cfg_we_i,
  input  streamer_pkg::reg_addr_e            cfg_addr_i,
  input  logic [DATA_W-1:0]                  cfg_wdata_i,
  input  logic [streamer_pkg::NUM_PORTS-1:0] chan_finished_i,
  output logic [DATA_W-1:0]                  cfg_rdata_o,
  output logic [streamer_pkg::NUM_PORTS-1:0] start_o,
  output logic [ADDR_W-1:0]                  base_o [streamer_pkg::NUM_PORTS],
  output logic [ADDR_W-1:0]                  stride_o [streamer_pkg::NUM_PORTS],
  output logic [streamer_pkg::LEN_W-1:0]     len_o [streamer_pkg::NUM_PORTS],
  output logic                               busy_o,
  output logic                               done_o
);
  import streamer_pkg::*;

  chan_state_e job_q;
  logic        start_q;
  logic        ctrl_wr;

  // Register address of field fld of channel chan
  function automatic reg_addr_e field_addr(input int chan, input int fld);
    return reg_addr_e'(int'(REG_X_BASE) + 3 * chan + fld);
  endfunction

  // Start accepted only while idle and no pulse pending
  assign ctrl_wr = cfg_we_i && (cfg_addr_i == REG_CTRL) && cfg_wdata_i[0] &&
                   (job_q == IDLE) && !start_q;

  assign start_o = {NUM_PORTS{start_q}};
  assign busy_o  = (job_q != IDLE);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int c = 0; c < NUM_PORTS; c++) begin
        base_o[c]   <= '0;
        stride_o[c] <= '0;
        len_o[c]    <= '0;
      end
    end else if (cfg_we_i) begin
      for (int c = 0; c < NUM_PORTS; c++) begin
        if (cfg_addr_i == field_addr(c, 0)) begin
          base_o[c] <= cfg_wdata_i[ADDR_W-1:0];
        end
        if (cfg_addr_i == field_addr(c, 1)) begin
          stride_o[c] <= cfg_wdata_i[ADDR_W-1:0];
        end
        if (cfg_addr_i == field_addr(c, 2)) begin
          len_o[c] <= cfg_wdata_i[LEN_W-1:0];
        end
      end
    end
  end

  // Job runs from the start pulse until every channel is finished
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      job_q   <= IDLE;
      start_q <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      start_q <= ctrl_wr;
      if (start_q) begin
        job_q  <= RUN;
        done_o <= 1'b0;
      end else if (job_q == RUN && (&chan_finished_i)) begin
        job_q  <= IDLE;
        done_o <= 1'b1;
      end
    end
  end

  // Readback, control reads as zero
  always_comb begin
    cfg_rdata_o = '0;
    if (cfg_addr_i == REG_STATUS) begin
      cfg_rdata_o = DATA_W'({done_o, busy_o});
    end
    for (int c = 0; c < NUM_PORTS; c++) begin
      if (cfg_addr_i == field_addr(c, 0)) begin
        cfg_rdata_o = DATA_W'(base_o[c]);
      end
      if (cfg_addr_i == field_addr(c, 1)) begin
        cfg_rdata_o = DATA_W'(stride_o[c]);
      end
      if (cfg_addr_i == field_addr(c, 2)) begin
        cfg_rdata_o = DATA_W'(len_o[c]);
      end
    end
  end

endmodule

//--- hw/streamer_top.sv
// Streamer top level
// Registers, three load channels, one store channel and the memory arbiter
`timescale 1ns/1ps

module streamer_top #(
  parameter int unsigned DATA_W     = streamer_pkg::DATA_W,
  parameter int unsigned ADDR_W     = streamer_pkg::ADDR_W,
  parameter int unsigned FIFO_DEPTH = streamer_pkg::FIFO_DEPTH
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // Shared memory port
  output logic                    mem_req_o,
  input  logic                    mem_gnt_i,
  output logic [ADDR_W-1:0]       mem_addr_o,
  output logic                    mem_wen_o,
  output logic [DATA_W-1:0]       mem_wdata_o,
  input  logic                    mem_rvalid_i,
  input  logic [DATA_W-1:0]       mem_rdata_i,
  // Operand streams
  output logic                    x_valid_o,
  input  logic                    x_ready_i,
  output logic [DATA_W-1:0]       x_data_o,
  output logic                    w_valid_o,
  input  logic                    w_ready_i,
  output logic [DATA_W-1:0]       w_data_o,
  output logic                    y_valid_o,
  input  logic                    y_ready_i,
  output logic [DATA_W-1:0]       y_data_o,
  // Result stream
  input  logic                    z_valid_i,
  output logic                    z_ready_o,
  input  logic [DATA_W-1:0]       z_data_i,
  // Configuration port
  input  logic                    cfg_we_i,
  input  streamer_pkg::reg_addr_e cfg_addr_i,
  input  logic [DATA_W-1:0]       cfg_wdata_i,
  output logic [DATA_W-1:0]       cfg_rdata_o,
  output logic                    busy_o,
  output logic                    done_o
);
  import streamer_pkg::*;

  logic [NUM_PORTS-1:0] start;
  logic [NUM_PORTS-1:0] finished;
  logic [ADDR_W-1:0]    base [NUM_PORTS];
  logic [ADDR_W-1:0]    stride [NUM_PORTS];
  logic [LEN_W-1:0]     len [NUM_PORTS];

  word_stream_if #(.DATA_W(DATA_W)) load_stream [NUM_SOURCES] ();
  word_stream_if #(.DATA_W(DATA_W)) z_stream ();
  mem_port_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) chan_port [NUM_PORTS] ();
  mem_port_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) mem_port ();

  // Memory port onto plain ports
  assign mem_req_o        = mem_port.req;
  assign mem_addr_o       = mem_port.addr;
  assign mem_wen_o        = mem_port.wen;
  assign mem_wdata_o      = mem_port.wdata;
  assign mem_port.gnt     = mem_gnt_i;
  assign mem_port.r_valid = mem_rvalid_i;
  assign mem_port.r_data  = mem_rdata_i;

  // Load streams by channel index
  assign x_valid_o               = load_stream[X_ID].valid;
  assign x_data_o                = load_stream[X_ID].data;
  assign load_stream[X_ID].ready = x_ready_i;
  assign w_valid_o               = load_stream[W_ID].valid;
  assign w_data_o                = load_stream[W_ID].data;
  assign load_stream[W_ID].ready = w_ready_i;
  assign y_valid_o               = load_stream[Y_ID].valid;
  assign y_data_o                = load_stream[Y_ID].data;
  assign load_stream[Y_ID].ready = y_ready_i;

  assign z_stream.valid = z_valid_i;
  assign z_stream.data  = z_data_i;
  assign z_ready_o      = z_stream.ready;

  streamer_regs #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) streamer_regs_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cfg_we_i        (cfg_we_i),
    .cfg_addr_i      (cfg_addr_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .chan_finished_i (finished),
    .cfg_rdata_o     (cfg_rdata_o),
    .start_o         (start),
    .base_o          (base),
    .stride_o        (stride),
    .len_o           (len),
    .busy_o          (busy_o),
    .done_o          (done_o)
  );

  for (genvar i = 0; i < NUM_SOURCES; i++) begin : g_source
    stream_source #(
      .DATA_W     (DATA_W),
      .ADDR_W     (ADDR_W),
      .FIFO_DEPTH (FIFO_DEPTH)
    ) stream_source_inst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .start_i    (start[i]),
      .base_i     (base[i]),
      .stride_i   (stride[i]),
      .len_i      (len[i]),
      .finished_o (finished[i]),
      .mem        (chan_port[i]),
      .stream_o   (load_stream[i])
    );
  end

  // Store channel takes the port after the loads
  stream_sink #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) stream_sink_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .start_i    (start[NUM_SOURCES]),
    .base_i     (base[NUM_SOURCES]),
    .stride_i   (stride[NUM_SOURCES]),
    .len_i      (len[NUM_SOURCES]),
    .finished_o (finished[NUM_SOURCES]),
    .mem        (chan_port[NUM_SOURCES]),
    .stream_i   (z_stream)
  );

  ldst_arbiter #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) ldst_arbiter_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .chan    (chan_port),
    .mem     (mem_port)
  );

endmodule

//--- test/streamer_chk.sv
// Streamer protocol checker
// Bound to the arbiter and to each load channel
`timescale 1ns/1ps

module streamer_chk #(
  parameter int unsigned DATA_W = 32,
  parameter int unsigned ADDR_W = 16,
  parameter int unsigned NUM_RV = 1,
  parameter int unsigned CNT_W  = 1,
  parameter int unsigned DEPTH  = 1
) (
  input logic              clk_i,
  input logic              reset_i,
  input logic              req_i,
  input logic              gnt_i,
  input logic [ADDR_W-1:0] addr_i,
  input logic              wen_i,
  input logic [NUM_RV-1:0] rvalid_i,
  input logic              s_valid_i,
  input logic              s_ready_i,
  input logic [DATA_W-1:0] s_data_i,
  input logic [CNT_W-1:0]  fill_i,
  input logic              push_i,
  input logic              pop_i
);

  // Waiting request keeps its address and direction
  assert property (@(posedge clk_i) disable iff (reset_i)
    req_i && !gnt_i |=> req_i && $stable(addr_i) && $stable(wen_i))
    else $error("memory request changed before grant");

  // Each accepted read is answered at one port only, one cycle later
  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(rvalid_i) && ((rvalid_i != '0) == $past(req_i && gnt_i && wen_i)))
    else $error("read response missing, extra or sent to more than one source");

  assert property (@(posedge clk_i) disable iff (reset_i)
    s_valid_i && !s_ready_i |=> s_valid_i && $stable(s_data_i))
    else $error("stream valid dropped or data changed before ready");

  // Full FIFO takes no push unless a word leaves
  assert property (@(posedge clk_i) disable iff (reset_i)
    (fill_i <= CNT_W'(DEPTH)) && !(push_i && !pop_i && fill_i == CNT_W'(DEPTH)))
    else $error("response FIFO overflow");

endmodule

bind ldst_arbiter streamer_chk #(
  .DATA_W (DATA_W),
  .ADDR_W (ADDR_W),
  .NUM_RV (streamer_pkg::NUM_PORTS)
) arb_chk_inst (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .req_i     (mem.req),
  .gnt_i     (mem.gnt),
  .addr_i    (mem.addr),
  .wen_i     (mem.wen),
  .rvalid_i  ({chan[3].r_valid, chan[2].r_valid, chan[1].r_valid, chan[0].r_valid}),
  .s_valid_i (1'b0),
  .s_ready_i (1'b0),
  .s_data_i  ('0),
  .fill_i    ('0),
  .push_i    (1'b0),
  .pop_i     (1'b0)
);

bind stream_source streamer_chk #(
  .DATA_W (DATA_W),
  .ADDR_W (ADDR_W),
  .NUM_RV (1),
  .CNT_W  (CNT_W),
  .DEPTH  (FIFO_DEPTH)
) src_chk_inst (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .req_i     (mem.req),
  .gnt_i     (mem.gnt),
  .addr_i    (mem.addr),
  .wen_i     (mem.wen),
  .rvalid_i  (mem.r_valid),
  .s_valid_i (stream_o.valid),
  .s_ready_i (stream_o.ready),
  .s_data_i  (stream_o.data),
  .fill_i    (count_q),
  .push_i    (push),
  .pop_i     (pop)
);

//--- test/tb_streamer.sv
// Streamer testbench
// Memory model with random grants, random stream handshakes and a job table
`timescale 1ns/1ps

module tb_streamer;
  import streamer_pkg::*;

  localparam int NUM_JOBS  = 6;
  localparam int JOB_COLS  = 15;
  localparam int WAIT_MAX  = 3000;
  localparam int MEM_WORDS = 4096;

  logic        clk_i;
  logic        reset_i;
  logic        mem_req_o;
  logic        mem_gnt_i;
  logic [15:0] mem_addr_o;
  logic        mem_wen_o;
  logic [31:0] mem_wdata_o;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;
  logic        x_valid_o;
  logic        x_ready_i;
  logic [31:0] x_data_o;
  logic        w_valid_o;
  logic        w_ready_i;
  logic [31:0] w_data_o;
  logic        y_valid_o;
  logic        y_ready_i;
  logic [31:0] y_data_o;
  logic        z_valid_i;
  logic        z_ready_o;
  logic [31:0] z_data_i;
  logic        cfg_we_i;
  reg_addr_e   cfg_addr_i;
  logic [31:0] cfg_wdata_i;
  logic [31:0] cfg_rdata_o;
  logic        busy_o;
  logic        done_o;

  // Memory contents and the contents expected after each job
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] lcg_state = 32'd96;
  int          value_errors = 0;
  int          other_errors = 0;
  bit          timed_out = 1'b0;
  // Current job, words seen per load stream and Z words sent
  int          cur_base [4];
  int          cur_stride [4];
  int          cur_len [4];
  int          cur_seed;
  int          got [3];
  int          z_idx = 0;
  int          x_stall = 0;
  string       sname [3] = '{"x_data_o", "w_data_o", "y_data_o"};

  // Columns: x base/stride/len, w base/stride/len, y base/stride/len,
  // z base/stride/len, z seed, x stall cycles, second start while busy
  int jobs [NUM_JOBS][JOB_COLS] = '{
    '{'h010, 1, 8, 'h100, 1, 8, 'h200, 2, 6, 'h800, 1, 8, 'h11, 0, 0},
    '{'h020, 3, 12, 'h180, 1, 16, 'h300, 5, 10, 'h900, 2, 12, 'h22, 0, 1},
    '{'h040, 1, 10, 'h1c0, 2, 5, 'h400, 1, 9, 'ha00, 1, 7, 'h33, 60, 0},
    '{'h050, 1, 0, 'h200, 4, 6, 'h500, 1, 0, 'hb00, 3, 0, 'h44, 0, 0},
    '{'h060, 7, 20, 'h260, 1, 0, 'h600, 1, 16, 'hc00, 1, 20, 'h55, 0, 0},
    '{'h000, 1, 0, 'h000, 1, 0, 'h000, 1, 0, 'hd00, 1, 0, 'h66, 0, 0}
  };

  streamer_top streamer_top_inst (.*);

  // Background word of every address
  function automatic logic [31:0] mem_word(input logic [15:0] a);
    return {a ^ 16'hc3a5, a * 16'd7 + 16'h01f0};
  endfunction

  // i-th Z word of a job
  function automatic logic [31:0] z_word(input int seed, input int idx);
    return (seed * 32'h0101_0101) ^ (idx * 32'h9e37_79b1) ^ 32'h5a00_0000;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic cfg_write(input reg_addr_e addr, input int data);
    @(posedge clk_i);
    #1;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #1;
    cfg_we_i = 1'b0;
  endtask

  task automatic readback_check(input reg_addr_e addr, input logic [31:0] exp);
    @(posedge clk_i);
    #1;
    cfg_addr_i = addr;
    @(negedge clk_i);
    if (cfg_rdata_o !== exp) begin
      value_errors++;
      $display("[FAIL] cfg_rdata_o %s exp=%h got=%h", addr.name(), exp, cfg_rdata_o);
    end
  endtask

  task automatic run_job(input int j);
    int n;
    @(negedge clk_i);
    for (int c = 0; c < 4; c++) begin
      cur_base[c]   = jobs[j][3 * c];
      cur_stride[c] = jobs[j][3 * c + 1];
      cur_len[c]    = jobs[j][3 * c + 2];
    end
    cur_seed = jobs[j][12];
    got      = '{0, 0, 0};
    z_idx    = 0;
    // Fields follow the register map from REG_X_BASE on
    for (int f = 0; f < 12; f++) begin
      cfg_write(reg_addr_e'(int'(REG_X_BASE) + f), jobs[j][f]);
      readback_check(reg_addr_e'(int'(REG_X_BASE) + f), jobs[j][f]);
    end
    cfg_write(REG_CTRL, 1);
    cfg_addr_i = REG_STATUS;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!busy_o && n < WAIT_MAX);
    if (!busy_o) begin
      other_errors++;
      $display("Job %0d never became busy after start", j);
      timed_out = 1'b1;
      return;
    end
    if (cfg_rdata_o !== 32'h1) begin
      value_errors++;
      $display("[FAIL] cfg_rdata_o status while busy exp=%h got=%h", 32'h1, cfg_rdata_o);
    end
    x_stall = jobs[j][13];
    // Start while busy must be ignored
    if (jobs[j][14] != 0) begin
      cfg_write(REG_CTRL, 1);
      cfg_addr_i = REG_STATUS;
    end
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!done_o && n < WAIT_MAX);
    if (!done_o) begin
      other_errors++;
      $display("Job %0d timed out waiting for done", j);
      timed_out = 1'b1;
      return;
    end
    if (cfg_rdata_o !== 32'h2) begin
      value_errors++;
      $display("[FAIL] cfg_rdata_o status after done exp=%h got=%h", 32'h2, cfg_rdata_o);
    end
    for (int s = 0; s < 3; s++) begin
      if (got[s] != cur_len[s]) begin
        value_errors++;
        $display("[FAIL] %s word count exp=%h got=%h", sname[s], cur_len[s], got[s]);
      end
    end
    if (z_idx != cur_len[3]) begin
      value_errors++;
      $display("[FAIL] z_data_i word count exp=%h got=%h", cur_len[3], z_idx);
    end
    repeat (3) @(negedge clk_i);
    if (busy_o || !done_o) begin
      other_errors++;
      $display("Job %0d restarted or lost done after it ended", j);
    end
    // Only the Z words may have changed in memory
    for (int i = 0; i < cur_len[3]; i++) begin
      ref_mem[12'(cur_base[3] + i * cur_stride[3])] = z_word(cur_seed, i);
    end
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (mem[a] !== ref_mem[a]) begin
        value_errors++;
        $display("[FAIL] mem[%h] exp=%h got=%h", a, ref_mem[a], mem[a]);
      end
    end
  endtask

  // Memory and stream model, sampled at the falling edge, driven after the rising edge
  initial begin : mem_model
    logic [31:0] r;
    logic        rd_acc;
    logic        wr_acc;
    logic        z_xfer;
    logic [15:0] rd_addr;
    logic [15:0] wr_addr;
    logic [31:0] wr_data;
    logic [2:0]  lv;
    logic [2:0]  lr;
    logic [31:0] ld [3];
    logic [31:0] exp;
    forever begin
      @(negedge clk_i);
      rd_acc  = !reset_i && mem_req_o && mem_gnt_i && mem_wen_o;
      wr_acc  = !reset_i && mem_req_o && mem_gnt_i && !mem_wen_o;
      rd_addr = mem_addr_o;
      wr_addr = mem_addr_o;
      wr_data = mem_wdata_o;
      z_xfer  = !reset_i && z_valid_i && z_ready_o;
      lv      = {y_valid_o, w_valid_o, x_valid_o};
      lr      = {y_ready_i, w_ready_i, x_ready_i};
      ld[0]   = x_data_o;
      ld[1]   = w_data_o;
      ld[2]   = y_data_o;
      for (int s = 0; s < 3; s++) begin
        if (!reset_i && lv[s] && lr[s]) begin
          exp = mem_word(16'(cur_base[s] + got[s] * cur_stride[s]));
          if (got[s] >= cur_len[s]) begin
            other_errors++;
            $display("Extra word on %s beyond the programmed length", sname[s]);
          end else if (ld[s] !== exp) begin
            value_errors++;
            $display("[FAIL] %s word %0d exp=%h got=%h", sname[s], got[s], exp, ld[s]);
          end
          got[s]++;
        end
      end
      if (wr_acc) begin
        exp = 32'(16'(cur_base[3] + z_idx * cur_stride[3]));
        if (32'(wr_addr) !== exp) begin
          value_errors++;
          $display("[FAIL] mem_addr_o write %0d exp=%h got=%h", z_idx, exp, wr_addr);
        end
        if (wr_data !== z_word(cur_seed, z_idx)) begin
          value_errors++;
          $display("[FAIL] mem_wdata_o write %0d exp=%h got=%h", z_idx,
                   z_word(cur_seed, z_idx), wr_data);
        end
      end
      @(posedge clk_i);
      #1;
      if (wr_acc) begin
        mem[wr_addr[11:0]] = wr_data;
      end
      // Read data comes back exactly one cycle after acceptance
      mem_rvalid_i = rd_acc;
      mem_rdata_i  = rd_acc ? mem[rd_addr[11:0]] : '0;
      if (z_xfer) begin
        z_idx++;
      end
      r = lcg_next();
      mem_gnt_i = r[31] | r[30];
      x_ready_i = (x_stall == 0) && r[29];
      if (x_stall > 0) begin
        x_stall--;
      end
      w_ready_i = r[28] | r[27];
      y_ready_i = r[26];
      // Z word held until taken
      if (!(z_valid_i && !z_xfer)) begin
        z_valid_i = (z_idx < cur_len[3]) && (r[25] | r[24]);
        z_data_i  = z_word(cur_seed, z_idx);
      end
    end
  end

  initial begin
    reset_i      = 1'b1;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    x_ready_i    = 1'b0;
    w_ready_i    = 1'b0;
    y_ready_i    = 1'b0;
    z_valid_i    = 1'b0;
    z_data_i     = '0;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = REG_CTRL;
    cfg_wdata_i  = '0;
    cur_base     = '{0, 0, 0, 0};
    cur_stride   = '{0, 0, 0, 0};
    cur_len      = '{0, 0, 0, 0};
    cur_seed     = 0;
    got          = '{0, 0, 0};
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]     = mem_word(16'(a));
      ref_mem[a] = mem[a];
    end
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    if ({mem_req_o, x_valid_o, w_valid_o, y_valid_o, z_ready_o, busy_o, done_o} !== 7'b0) begin
      other_errors++;
      $display("Outputs not idle after reset");
    end
    for (int j = 0; j < NUM_JOBS && !timed_out; j++) begin
      run_job(j);
    end
    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- project.f
common/streamer_pkg.sv
common/mem_port_if.sv
common/word_stream_if.sv
streamer/stream_source.sv
streamer/stream_sink.sv
streamer/ldst_arbiter.sv
hw/streamer_regs.sv
hw/streamer_top.sv
test/streamer_chk.sv
test/tb_streamer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_streamer
RTL_TOP   := streamer_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
